// ==== flist.f ====
verilog/vicPkg.sv
verilog/cycleSequencer.sv
verilog/matrixFetch.sv
verilog/memArbiter.sv
verilog/videoRam.sv
verilog/charLineBuffer.sv
verilog/charFetchTop.sv
verification/tbClock.sv
verification/charFetchTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the character fetch testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module charFetchTb -f flist.f -o VcharFetchTb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VcharFetchTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
	exit 0
else
	echo "Pass message not found in $LOG"
	exit 1
fi

// ==== verification/charFetchPatterns.txt ====
# Columns are command, address and data. W writes data (hex) and R reads with expected word (hex)
# L watches a number of raster lines (decimal). The first command starts on frame line 0
#
# Line 0 badline of row 0, writes land in rows 1 and 2
W 02A 123
W 051 3C7
R 02A 123
R 051 3C7
L 8
# Line 8 badline of row 1, writes into rows 0 and 3
W 005 7E1
W 096 B0B
R 005 7E1
L 4
# Line 12 replays row 1 from the buffer
W 010 444
R 010 444
W 060 9F9
L 4
# Line 16 badline of row 2
R 060 9F9
L 16
# Line 0 of the next frame fetches row 0 again with the new words
W 09F 0A1
R 09F 0A1
L 25
R 096 B0B

// ==== verification/charFetchTb.sv ====
// Testbench for the character fetch path
// Replays host commands from the patterns file and checks every fetched character
`timescale 1ns/1ps
`default_nettype none

module charFetchTb;
	import vicPkg::*;

	logic clk33;
	logic rst;
	logic hostReq;
	logic hostWe;
	logic [AddrWidth-1:0] hostAddr;
	logic [CharWidth-1:0] hostWrData;
	logic hostAck;
	logic [CharWidth-1:0] hostRdData;
	logic [CharWidth-1:0] charOut;
	logic charValid;
	logic [RasterWidth-1:0] rasterLine;
	logic badline;

	// Reference copy of the video RAM, built only from the host writes
	logic [CharWidth-1:0] model [2**AddrWidth];
	// Words taken on the badline, expected again on the other seven lines
	logic [CharWidth-1:0] shadow [ColCount];
	bit listed [2**AddrWidth];

	byte cmdOp[$];
	int cmdAddr[$];
	int cmdData[$];

	int errorCount = 0;
	int checkCount = 0;
	int monErrors = 0;
	int monChecks = 0;
	int prevLine = 0;
	int colIdx = 0;
	int linesSeen = 0;
	bit armChecks = 1'b0;
	bit checkOn = 1'b0;
	longint watchLimitNs = 0;

	tbClock uClock (
		.clk33(clk33),
		.rst(rst)
	);

	charFetchTop i_dut (
		.clk33(clk33),
		.rst(rst),
		.hostReq(hostReq),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostWrData(hostWrData),
		.hostAck(hostAck),
		.hostRdData(hostRdData),
		.charOut(charOut),
		.charValid(charValid),
		.rasterLine(rasterLine),
		.badline(badline)
	);

	// ==============================
	// Compare tasks
	// ==============================
	task automatic checkChar(input logic [CharWidth-1:0] got,
			input logic [CharWidth-1:0] expected, input int col);
		monChecks++;
		if (got !== expected) begin
			$display("[FAIL] %0d ns: line %0d column %0d gave char %03h, expected %03h",
				$time, rasterLine, col, got, expected);
			monErrors++;
		end
	endtask

	task automatic checkHostRead(input logic [AddrWidth-1:0] addr,
			input logic [CharWidth-1:0] got, input logic [CharWidth-1:0] expected);
		checkCount++;
		if (got !== expected) begin
			$display("[FAIL] %0d ns: host read of %03h returned %03h, expected %03h",
				$time, addr, got, expected);
			errorCount++;
		end
	endtask

	// Raster counter steps by one and wraps, badline marks the first line of each row
	task automatic compareRaster(input logic [RasterWidth-1:0] got, input logic gotBadline,
			input int expLine);
		monChecks++;
		if (got !== RasterWidth'(expLine) || gotBadline !== ((expLine % LinesPerRow) == 0)) begin
			$display("[FAIL] %0d ns: raster line %0d badline %0b, expected line %0d",
				$time, got, gotBadline, expLine);
			monErrors++;
		end
	endtask

	// ==============================
	// Host port and pattern helpers
	// ==============================
	task automatic hostTransfer(input logic we, input logic [AddrWidth-1:0] addr,
			input logic [CharWidth-1:0] wrData, output logic [CharWidth-1:0] rdData,
			output int latency);
		int holdCount;
		rdData = '0;
		latency = 0;
		holdCount = 0;
		@(posedge clk33);
		#1;
		if (hostAck !== 1'b0) begin
			$display("ERROR: hostAck was already high before hostReq rose at %0d ns", $time);
			errorCount++;
		end
		hostReq = 1'b1;
		hostWe = we;
		hostAddr = addr;
		hostWrData = wrData;
		// The rise of hostAck ends the host latency, badline fetches stretch it
		while (hostAck !== 1'b1 && latency < 400) begin
			@(negedge clk33);
			latency++;
		end
		if (hostAck !== 1'b1) begin
			$display("ERROR: no hostAck for address %03h within 400 clocks", addr);
			errorCount++;
		end
		rdData = hostRdData;
		@(posedge clk33);
		#1;
		hostReq = 1'b0;
		@(negedge clk33);
		if (hostAck !== 1'b1) begin
			$display("ERROR: hostAck fell before the arbiter saw hostReq low at %0d ns", $time);
			errorCount++;
		end
		while (hostAck !== 1'b0 && holdCount < 8) begin
			@(negedge clk33);
			holdCount++;
		end
		if (hostAck !== 1'b0) begin
			$display("ERROR: hostAck stayed high after hostReq fell at %0d ns", $time);
			errorCount++;
		end
	endtask

	task automatic waitLines(input int count);
		int target;
		target = linesSeen + count;
		wait (linesSeen >= target);
	endtask

	task automatic readPatterns(output int totalLines);
		int fd;
		int n;
		int a;
		int d;
		string lineBuf;
		string opStr;
		totalLines = 0;
		fd = $fopen("verification/charFetchPatterns.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open the patterns file");
			errorCount++;
			return;
		end
		while ($fgets(lineBuf, fd) != 0) begin
			if (lineBuf.len() == 0 || lineBuf.getc(0) == "#") continue;
			if ($sscanf(lineBuf, "%s", opStr) != 1) continue;
			a = 0;
			d = 0;
			// Line counts are decimal, addresses and words are hex
			if (opStr == "L") begin
				n = $sscanf(lineBuf, "%s %d", opStr, a) + 1;
				totalLines += a;
			end else begin
				n = $sscanf(lineBuf, "%s %h %h", opStr, a, d);
				if (opStr == "W") listed[a] = 1'b1;
			end
			if (n != 3) begin
				$display("ERROR: malformed pattern line %s", lineBuf);
				errorCount++;
			end
			cmdOp.push_back(opStr.getc(0));
			cmdAddr.push_back(a);
			cmdData.push_back(d);
		end
		$fclose(fd);
	endtask

	// ==============================
	// Character stream monitor
	// ==============================
	always @(negedge clk33) begin
		if (!rst) begin
			if (int'(rasterLine) != prevLine) begin
				compareRaster(rasterLine, badline, (prevLine + 1) % RasterLines);
				if (checkOn && colIdx != ColCount) begin
					$display("ERROR: raster line %0d carried %0d characters instead of %0d",
						prevLine, colIdx, ColCount);
					monErrors++;
				end
				// The expected raster line keeps its own count from reset
				prevLine = (prevLine + 1) % RasterLines;
				// Character checks start on the top of a frame, where rowBase is 0
				if (armChecks && prevLine == 0) checkOn = 1'b1;
				colIdx = 0;
				linesSeen++;
			end
			if (charValid) begin
				if (checkOn && colIdx >= ColCount) begin
					$display("ERROR: extra character on raster line %0d", prevLine);
					monErrors++;
				end else if (checkOn) begin
					// First line of a row takes fresh words, the other seven replay them
					if ((prevLine % LinesPerRow) == 0) begin
						shadow[colIdx] = model[(prevLine / LinesPerRow) * ColCount + colIdx];
					end
					checkChar(charOut, shadow[colIdx], colIdx);
				end
				colIdx++;
			end
		end
	end

	initial begin : watchdog
		wait (watchLimitNs != 0);
		#(watchLimitNs);
		$display("ERROR: the run timed out after %0d ns before all commands finished",
			watchLimitNs);
		$display("Testbench failed");
		$finish;
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin : mainFlow
		logic [CharWidth-1:0] rdData;
		logic [CharWidth-1:0] fillData;
		int latency;
		int totalLines;
		int i;
		hostReq = 1'b0;
		hostWe = 1'b0;
		hostAddr = '0;
		hostWrData = '0;
		void'($urandom(32'h8a35));
		readPatterns(totalLines);
		// Listed lines plus fill and sync, then the host traffic, then a margin
		watchLimitNs = longint'(totalLines + 2 * RasterLines) * LineCycles * 2 * 100
			+ longint'(CharRows * ColCount + cmdOp.size()) * 20 * 100 + 50000;
		wait (rst === 1'b1);
		wait (rst === 1'b0);

		// Listed words start at zero, so the screen is known before their commands
		for (i = 0; i < CharRows * ColCount; i++) begin
			fillData = listed[i] ? '0 : CharWidth'($urandom());
			model[i] = fillData;
			hostTransfer(1'b1, AddrWidth'(i), fillData, rdData, latency);
		end
		$display("Filled %0d words of video matrix", CharRows * ColCount);
		armChecks = 1'b1;
		wait (checkOn);

		for (i = 0; i < cmdOp.size(); i++) begin
			case (cmdOp[i])
				"W": begin
					model[cmdAddr[i]] = CharWidth'(cmdData[i]);
					hostTransfer(1'b1, AddrWidth'(cmdAddr[i]), CharWidth'(cmdData[i]),
						rdData, latency);
					$display("W %03h <= %03h, ack after %0d clocks on raster line %0d",
						cmdAddr[i], cmdData[i], latency, rasterLine);
				end
				"R": begin
					hostTransfer(1'b0, AddrWidth'(cmdAddr[i]), '0, rdData, latency);
					checkHostRead(AddrWidth'(cmdAddr[i]), rdData, CharWidth'(cmdData[i]));
					$display("R %03h -> %03h, ack after %0d clocks", cmdAddr[i], rdData, latency);
				end
				"L": begin
					waitLines(cmdAddr[i]);
					$display("L %0d lines watched, now on raster line %0d", cmdAddr[i], rasterLine);
				end
				default: begin
					$display("ERROR: unknown command %c in the patterns file", cmdOp[i]);
					errorCount++;
				end
			endcase
		end

		$display("Commands %0d, checks %0d, errors %0d", cmdOp.size(),
			checkCount + monChecks, errorCount + monErrors);
		if (errorCount + monErrors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/tbClock.sv ====
// Testbench clock and reset source
// Makes clk33 with a 100 ns period and holds rst high for the first three cycles
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk33,
	output logic rst
);

	// Half of the 100 ns period
	initial begin
		clk33 = 1'b0;
		forever #50 clk33 = ~clk33;
	end

	// Release lands just after the third rising edge, like every other driven input
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk33);
		#1;
		rst = 1'b0;
	end

endmodule

`default_nettype wire

// ==== verilog/charFetchTop.sv ====
// Character fetch path top level
// Sequencer, matrix fetcher, arbiter, video RAM and line buffer
`timescale 1ns/1ps
`default_nettype none

module charFetchTop (
	input wire logic clk33,
	input wire logic rst,
	input wire logic hostReq,
	input wire logic hostWe,
	input wire logic [vicPkg::AddrWidth-1:0] hostAddr,
	input wire logic [vicPkg::CharWidth-1:0] hostWrData,
	output logic hostAck,
	output logic [vicPkg::CharWidth-1:0] hostRdData,
	output logic [vicPkg::CharWidth-1:0] charOut,
	output logic charValid,
	output logic [vicPkg::RasterWidth-1:0] rasterLine,
	output logic badline
);
	import vicPkg::*;

	// ==============================
	// Internal nets
	// ==============================
	logic phi02;
	logic [LineCycleWidth-1:0] lineCycle;
	busCycle_t busCycle;
	logic fetchReq;
	logic [AddrWidth-1:0] fetchAddr;
	logic [AddrWidth-1:0] memAddr;
	logic memWe;
	logic [CharWidth-1:0] memWrData;
	logic [CharWidth-1:0] memRdData;

	// Timing source for everything below
	cycleSequencer uSeq (
		.clk33(clk33),
		.rst(rst),
		.phi02(phi02),
		.lineCycle(lineCycle),
		.busCycle(busCycle),
		.rasterLine(rasterLine),
		.badline(badline)
	);

	matrixFetch uFetch (
		.clk33(clk33),
		.rst(rst),
		.phi02(phi02),
		.busCycle(busCycle),
		.lineCycle(lineCycle),
		.rasterLine(rasterLine),
		.badline(badline),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr)
	);

	memArbiter uArb (
		.clk33(clk33),
		.rst(rst),
		.fetchReq(fetchReq),
		.fetchAddr(fetchAddr),
		.hostReq(hostReq),
		.hostWe(hostWe),
		.hostAddr(hostAddr),
		.hostWrData(hostWrData),
		.hostAck(hostAck),
		.hostRdData(hostRdData),
		.memAddr(memAddr),
		.memWe(memWe),
		.memWrData(memWrData),
		.memRdData(memRdData)
	);

	videoRam uRam (
		.clk33(clk33),
		.memAddr(memAddr),
		.memWe(memWe),
		.memWrData(memWrData),
		.memRdData(memRdData)
	);

	// Sees every RAM read but only keeps the ones from character cycles
	charLineBuffer uLineBuf (
		.clk33(clk33),
		.rst(rst),
		.phi02(phi02),
		.busCycle(busCycle),
		.badline(badline),
		.memRdData(memRdData),
		.charOut(charOut),
		.charValid(charValid)
	);

endmodule

`default_nettype wire

// ==== verilog/charLineBuffer.sv ====
// Character line buffer
// Captures forty fetched words on a badline and replays them on the row's other lines
`timescale 1ns/1ps
`default_nettype none

module charLineBuffer (
	input wire logic clk33,
	input wire logic rst,
	input wire logic phi02,
	input wire vicPkg::busCycle_t busCycle,
	input wire logic badline,
	input wire logic [vicPkg::CharWidth-1:0] memRdData,
	output logic [vicPkg::CharWidth-1:0] charOut,
	output logic charValid
);
	import vicPkg::*;

	logic [CharWidth-1:0] charBuf [ColCount];
	logic shiftEn;

	// Fetched data is on the RAM output in the second half of a character cycle
	assign shiftEn = phi02 && (busCycle == VIC_CHAR);

	// ==============================
	// Shift and recirculate
	// ==============================
	always_ff @(posedge clk33) begin
		if (rst) begin
			for (int i = 0; i < ColCount; i++) begin
				charBuf[i] <= '0;
			end
			charValid <= 1'b0;
		end else begin
			charValid <= shiftEn;
			if (shiftEn) begin
				for (int i = 1; i < ColCount; i++) begin
					charBuf[i] <= charBuf[i-1];
				end
				// Badlines take fresh data, other lines feed the tail back to the head
				if (badline) begin
					charBuf[0] <= memRdData;
				end else begin
					charBuf[0] <= charBuf[ColCount-1];
				end
			end
		end
	end

	// Head of the buffer is the character that was just shifted in
	assign charOut = charBuf[0];

	// A character appears only right after a phi02-high clock
	assert property (@(posedge clk33) disable iff (rst)
		charValid |-> ($past(phi02) && !phi02));

endmodule

`default_nettype wire

// ==== verilog/cycleSequencer.sv ====
// Video bus cycle sequencer
// Splits every raster line into 48 two-clock bus cycles and flags the badlines
`timescale 1ns/1ps
`default_nettype none

module cycleSequencer (
	input wire logic clk33,
	input wire logic rst,
	output logic phi02,
	output logic [vicPkg::LineCycleWidth-1:0] lineCycle,
	output vicPkg::busCycle_t busCycle,
	output logic [vicPkg::RasterWidth-1:0] rasterLine,
	output logic badline
);
	import vicPkg::*;

	logic lineEnd;

	// The last clock of the last bus cycle closes the raster line
	assign lineEnd = phi02 && (lineCycle == LineCycleWidth'(LineCycles - 1));

	// ==============================
	// Phase, cycle and raster counters
	// ==============================
	always_ff @(posedge clk33) begin
		if (rst) begin
			phi02 <= 1'b0;
			lineCycle <= '0;
			rasterLine <= '0;
		end else begin
			phi02 <= ~phi02;
			// A bus cycle ends after its phi02-high clock
			if (phi02) begin
				if (lineEnd) begin
					lineCycle <= '0;
				end else begin
					lineCycle <= lineCycle + 1'b1;
				end
			end
			if (lineEnd) begin
				if (rasterLine == RasterWidth'(RasterLines - 1)) begin
					rasterLine <= '0;
				end else begin
					rasterLine <= rasterLine + 1'b1;
				end
			end
		end
	end

	// Character cycles come first, then the refresh slots, then idle to line end
	always_comb begin
		if (lineCycle < LineCycleWidth'(ColCount)) begin
			busCycle = VIC_CHAR;
		end else if (lineCycle < LineCycleWidth'(ColCount + 4)) begin
			busCycle = VIC_REF;
		end else begin
			busCycle = VIC_IDLE;
		end
	end

	// First raster line of each character row fetches the matrix
	assign badline = ((rasterLine & RasterWidth'(LinesPerRow - 1)) == '0);

	// The cycle counter must wrap before it leaves the line
	assert property (@(posedge clk33) disable iff (rst)
		lineCycle < LineCycleWidth'(LineCycles));

endmodule

`default_nettype wire

// ==== verilog/matrixFetch.sv ====
// Video matrix fetcher
// Issues one character read per character cycle of a badline from the row base
`timescale 1ns/1ps
`default_nettype none

module matrixFetch (
	input wire logic clk33,
	input wire logic rst,
	input wire logic phi02,
	input wire vicPkg::busCycle_t busCycle,
	input wire logic [vicPkg::LineCycleWidth-1:0] lineCycle,
	input wire logic [vicPkg::RasterWidth-1:0] rasterLine,
	input wire logic badline,
	output logic fetchReq,
	output logic [vicPkg::AddrWidth-1:0] fetchAddr
);
	import vicPkg::*;

	logic [AddrWidth-1:0] rowBase;
	logic lineEnd;

	assign lineEnd = phi02 && (lineCycle == LineCycleWidth'(LineCycles - 1));

	// ==============================
	// Row base address
	// ==============================
	always_ff @(posedge clk33) begin
		if (rst) begin
			rowBase <= '0;
		end else if (lineEnd) begin
			// Frame wrap takes precedence, the last line is never a badline anyway
			if (rasterLine == RasterWidth'(RasterLines - 1)) begin
				rowBase <= '0;
			end else if (badline) begin
				rowBase <= rowBase + AddrWidth'(ColCount);
			end
		end
	end

	// The request rides in the first half of the bus cycle
	assign fetchReq = badline && !phi02 && (busCycle == VIC_CHAR);

	// Column number is the cycle number during the character cycles
	assign fetchAddr = rowBase + {{(AddrWidth - LineCycleWidth){1'b0}}, lineCycle};

endmodule

`default_nettype wire

// ==== verilog/memArbiter.sv ====
// Video RAM arbiter
// Fetcher has absolute priority, host gets a four-phase req/ack port
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
	input wire logic clk33,
	input wire logic rst,
	input wire logic fetchReq,
	input wire logic [vicPkg::AddrWidth-1:0] fetchAddr,
	input wire logic hostReq,
	input wire logic hostWe,
	input wire logic [vicPkg::AddrWidth-1:0] hostAddr,
	input wire logic [vicPkg::CharWidth-1:0] hostWrData,
	output logic hostAck,
	output logic [vicPkg::CharWidth-1:0] hostRdData,
	output logic [vicPkg::AddrWidth-1:0] memAddr,
	output logic memWe,
	output logic [vicPkg::CharWidth-1:0] memWrData,
	input wire logic [vicPkg::CharWidth-1:0] memRdData
);
	import vicPkg::*;

	arbState_t state;
	logic hostGrant;

	// Host owns the RAM only in a clock the fetcher leaves free
	assign hostGrant = (state == ARB_IDLE) && hostReq && !fetchReq;

	// ==============================
	// RAM port mux
	// ==============================
	always_comb begin
		if (fetchReq) begin
			memAddr = fetchAddr;
		end else begin
			memAddr = hostAddr;
		end
	end

	// Writes happen only in a clock granted to the host
	assign memWe = hostGrant && hostWe;

	// Only the host ever writes
	assign memWrData = hostWrData;

	// ==============================
	// Host handshake FSM
	// ==============================
	always_ff @(posedge clk33) begin
		if (rst) begin
			state <= ARB_IDLE;
		end else begin
			case (state)
				ARB_IDLE: begin
					// Writes land at the grant edge, reads wait for the RAM
					if (hostGrant) begin
						state <= hostWe ? ARB_ACK : ARB_READ;
					end
				end
				ARB_READ: begin
					state <= ARB_ACK;
				end
				ARB_ACK: begin
					if (!hostReq) begin
						state <= ARB_RELEASE;
					end
				end
				ARB_RELEASE: begin
					// One quiet clock before the next request is looked at
					state <= ARB_IDLE;
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	// Read data comes out of the RAM one clock after the grant
	always_ff @(posedge clk33) begin
		if (state == ARB_READ) begin
			hostRdData <= memRdData;
		end
	end

	assign hostAck = (state == ARB_ACK);

	// An ack only ever answers a pending request
	assert property (@(posedge clk33) disable iff (rst)
		$rose(hostAck) |-> hostReq);

	// A host write must never collide with a matrix fetch
	assert property (@(posedge clk33) disable iff (rst)
		fetchReq |-> !memWe);

endmodule

`default_nettype wire

// ==== verilog/vicPkg.sv ====
// Shared definitions for the character fetch path
// Bus cycle and host handshake encodings, frame geometry and bus widths
`default_nettype none

package vicPkg;

	// ==============================
	// Geometry and widths
	// ==============================

	// One character word is an 8-bit code plus a 4-bit attribute nibble
	localparam int CharWidth = 12;
	localparam int AddrWidth = 10;

	// Forty text columns fit in the first forty bus cycles of a line
	localparam int ColCount = 40;
	localparam int LineCycles = 48;
	localparam int CharRows = 4;
	localparam int LinesPerRow = 8;

	// Derived frame sizes
	localparam int RasterLines = CharRows * LinesPerRow;
	localparam int LineCycleWidth = $clog2(LineCycles);
	localparam int RasterWidth = $clog2(RasterLines);

	// ==============================
	// Encodings
	// ==============================

	// Kind of video access owned by the current bus cycle
	typedef enum logic [1:0] {
		VIC_IDLE,
		VIC_CHAR,
		VIC_REF
	} busCycle_t;

	// Host side of the memory arbiter
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_READ,
		ARB_ACK,
		ARB_RELEASE
	} arbState_t;

endpackage

`default_nettype wire

// ==== verilog/videoRam.sv ====
// Video RAM, 1024 words of 12 bits
// Single port, write-through is not used, reads return one clock later
`timescale 1ns/1ps
`default_nettype none

module videoRam (
	input wire logic clk33,
	input wire logic [vicPkg::AddrWidth-1:0] memAddr,
	input wire logic memWe,
	input wire logic [vicPkg::CharWidth-1:0] memWrData,
	output logic [vicPkg::CharWidth-1:0] memRdData
);
	import vicPkg::*;

	logic [CharWidth-1:0] mem [2**AddrWidth];

	// Read returns the old word when the same address is written
	always_ff @(posedge clk33) begin
		if (memWe) begin
			mem[memAddr] <= memWrData;
		end
		memRdData <= mem[memAddr];
	end

endmodule

`default_nettype wire
